// ==== verilog/fp_sum_pkg.sv ====
package fp_sum_pkg;

    // ======================================================================
    // widths
    // ======================================================================

    // operands per item.
    localparam int LANES = 8;

    // single-precision fields.
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int WORD_W = 1 + EXP_W + FRAC_W;

    // implicit one, three headroom bits, fraction.
    localparam int MANT_W = 27;

    // signed accumulator for the eight-way sum.
    localparam int SUM_W = 32;

    // bit index into a SUM_W value.
    localparam int LEAD_W = 5;

    // ======================================================================
    // types
    // ======================================================================

    typedef logic [WORD_W-1:0] fp_word_t;

    // one item, lane 0 in the low word.
    typedef fp_word_t [LANES-1:0] fp_word_vec_t;

    typedef logic [EXP_W-1:0] exp_t;

    typedef logic [MANT_W-1:0] mant_t;

    typedef logic signed [SUM_W-1:0] sum_t;

    typedef logic [LEAD_W-1:0] lead_t;

endpackage

// ==== verilog/fp_lanes_if.sv ====
interface fp_lanes_if;
    import fp_sum_pkg::*;

    // item strobe, one level per item.
    logic valid;

    // unpacked fields, one entry per lane.
    logic  [LANES-1:0] sign;
    exp_t  [LANES-1:0] exp;
    mant_t [LANES-1:0] mant;

    // decode side.
    modport source (
        output valid,
        output sign,
        output exp,
        output mant
    );

    // execute side.
    modport sink (
        input valid,
        input sign,
        input exp,
        input mant
    );

endinterface

// ==== verilog/lead_one_find.sv ====
module lead_one_find (
    input  fp_sum_pkg::sum_t  value,
    output fp_sum_pkg::lead_t pos
);
    import fp_sum_pkg::*;

    // scan upward so the highest set bit wins.
    // zero input leaves pos at 0.
    always_comb begin
        pos = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (value[i]) begin
                pos = lead_t'(i);
            end
        end
    end

endmodule

// ==== verilog/fp_unpack.sv ====
module fp_unpack (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  fp_sum_pkg::fp_word_vec_t in_words,
    fp_lanes_if.source               lanes
);
    import fp_sum_pkg::*;

    logic  [LANES-1:0] sign_c;
    exp_t  [LANES-1:0] exp_c;
    mant_t [LANES-1:0] mant_c;

    // ======================================================================
    // field split
    // ======================================================================

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            sign_c[i] = in_words[i][WORD_W-1];
            exp_c[i]  = in_words[i][WORD_W-2 -: EXP_W];
            // implicit one always set, denormals not handled.
            mant_c[i] = {{(MANT_W-FRAC_W-1){1'b0}}, 1'b1, in_words[i][FRAC_W-1:0]};
        end
    end

    // ======================================================================
    // stage register
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            lanes.valid <= 1'b0;
        end else begin
            lanes.valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        lanes.sign <= sign_c;
        lanes.exp  <= exp_c;
        lanes.mant <= mant_c;
    end

endmodule

// ==== verilog/fp_align_sum.sv ====
module fp_align_sum (
    input  logic             clk,
    input  logic             rst,
    fp_lanes_if.sink         lanes,
    output logic             sum_valid,
    output fp_sum_pkg::sum_t sum,
    output fp_sum_pkg::exp_t max_exp
);
    import fp_sum_pkg::*;

    exp_t  lvl1 [LANES/2];
    exp_t  lvl2 [LANES/4];
    exp_t  max_exp_c;
    exp_t  diff [LANES];
    mant_t shifted [LANES];
    sum_t  term [LANES];
    sum_t  sum_c;

    // ======================================================================
    // largest exponent
    // ======================================================================

    always_comb begin
        for (int i = 0; i < LANES/2; i++) begin
            lvl1[i] = (lanes.exp[2*i] > lanes.exp[2*i+1]) ? lanes.exp[2*i]
                                                          : lanes.exp[2*i+1];
        end
        for (int i = 0; i < LANES/4; i++) begin
            lvl2[i] = (lvl1[2*i] > lvl1[2*i+1]) ? lvl1[2*i] : lvl1[2*i+1];
        end
        max_exp_c = (lvl2[0] > lvl2[1]) ? lvl2[0] : lvl2[1];
    end

    // ======================================================================
    // align and add
    // ======================================================================

    always_comb begin
        sum_c = '0;
        for (int i = 0; i < LANES; i++) begin
            diff[i] = max_exp_c - lanes.exp[i];
            // truncating shift, bits below the lsb are lost.
            shifted[i] = lanes.mant[i] >> diff[i];
            term[i] = lanes.sign[i] ? -sum_t'(shifted[i]) : sum_t'(shifted[i]);
            sum_c = sum_c + term[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= lanes.valid;
        end
    end

    always_ff @(posedge clk) begin
        sum     <= sum_c;
        max_exp <= max_exp_c;
    end

    // tree result must dominate every lane.
    for (genvar g = 0; g < LANES; g++) begin : g_shift_chk
        a_shift_range: assert property (
            @(posedge clk) disable iff (rst)
            lanes.valid |-> (diff[g] <= max_exp_c)
        );
    end

endmodule

// ==== verilog/fp_normalize_pack.sv ====
module fp_normalize_pack (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sum_valid,
    input  fp_sum_pkg::sum_t     sum,
    input  fp_sum_pkg::exp_t     max_exp,
    output logic                 out_valid,
    output fp_sum_pkg::fp_word_t out_word
);
    import fp_sum_pkg::*;

    logic     sign_c;
    sum_t     mag;
    lead_t    lead;
    sum_t     norm;
    exp_t     exp_c;
    fp_word_t word_c;

    // ======================================================================
    // magnitude and leading one
    // ======================================================================

    assign sign_c = sum[SUM_W-1];
    assign mag    = sign_c ? -sum : sum;

    lead_one_find u_lead (
        .value (mag),
        .pos   (lead)
    );

    // ======================================================================
    // normalize and pack
    // ======================================================================

    always_comb begin
        // bring the leading one to bit FRAC_W.
        if (lead > lead_t'(FRAC_W)) begin
            norm = mag >> (lead - lead_t'(FRAC_W));
        end else begin
            norm = mag << (lead_t'(FRAC_W) - lead);
        end
        exp_c = max_exp + exp_t'(lead) - exp_t'(FRAC_W);
        if (mag == '0) begin
            word_c = '0;
        end else begin
            word_c = {sign_c, exp_c, norm[FRAC_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        out_word <= word_c;
    end

    // nonzero totals end with the leading one on bit FRAC_W.
    a_norm_lead: assert property (
        @(posedge clk) disable iff (rst)
        (sum_valid && mag != '0) |-> ((norm >> FRAC_W) == sum_t'(1))
    );

endmodule

// ==== verilog/fp_sum8.sv ====
module fp_sum8 (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    input  fp_sum_pkg::fp_word_vec_t in_words,
    output logic                     out_valid,
    output fp_sum_pkg::fp_word_t     out_word
);
    import fp_sum_pkg::*;

    logic sum_valid;
    sum_t sum;
    exp_t max_exp;

    // decode to execute.
    fp_lanes_if lanes ();

    // ======================================================================
    // three stage pipeline, one item per cycle
    // ======================================================================

    fp_unpack u_unpack (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_words (in_words),
        .lanes    (lanes.source)
    );

    fp_align_sum u_align_sum (
        .clk       (clk),
        .rst       (rst),
        .lanes     (lanes.sink),
        .sum_valid (sum_valid),
        .sum       (sum),
        .max_exp   (max_exp)
    );

    fp_normalize_pack u_normalize_pack (
        .clk       (clk),
        .rst       (rst),
        .sum_valid (sum_valid),
        .sum       (sum),
        .max_exp   (max_exp),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

endmodule

// ==== bench/fp_sum8_tb.sv ====
module fp_sum8_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import fp_sum_pkg::*;

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 16;
    localparam int IDLE_CYCLES    = 4;
    localparam int PIPE_DEPTH     = 3;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int RANDOM_ROWS    = 6;

    // operand words.
    localparam fp_word_t ONE            = 32'h3F80_0000;
    localparam fp_word_t NEG_ONE        = 32'hBF80_0000;
    localparam fp_word_t HALF           = 32'h3F00_0000;
    localparam fp_word_t NEG_HALF       = 32'hBF00_0000;
    localparam fp_word_t THREE          = 32'h4040_0000;
    localparam fp_word_t NEG_FOUR       = 32'hC080_0000;
    localparam fp_word_t ALMOST_ONE     = 32'h3F7F_FFFF;
    localparam fp_word_t NEG_ALMOST_ONE = 32'hBF7F_FFFF;
    localparam fp_word_t TINY           = 32'h3080_0000;

    logic         clk;
    logic         rst;
    logic         in_valid;
    fp_word_vec_t in_words;
    logic         out_valid;
    fp_word_t     out_word;

    string        names[$];
    fp_word_vec_t stim_q[$];
    fp_word_t     expect_q[$];
    int           sent_cycle_q[$];

    int     cycle = 0;
    int     errors = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    logic   timed_out = 1'b0;
    integer seed = 32'h9d6c;

    fp_sum8 UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_words  (in_words),
        .out_valid (out_valid),
        .out_word  (out_word)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ======================================================================
    // helpers
    // ======================================================================

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("pass %s", name);
            tests_passed++;
        end else begin
            $display("fail %s", name);
            tests_failed++;
        end
    endtask

    task automatic add_row(input string name,
                           input fp_word_t w0, input fp_word_t w1,
                           input fp_word_t w2, input fp_word_t w3,
                           input fp_word_t w4, input fp_word_t w5,
                           input fp_word_t w6, input fp_word_t w7,
                           input fp_word_t expected);
        fp_word_vec_t v;
        v[0] = w0;
        v[1] = w1;
        v[2] = w2;
        v[3] = w3;
        v[4] = w4;
        v[5] = w5;
        v[6] = w6;
        v[7] = w7;
        names.push_back(name);
        stim_q.push_back(v);
        expect_q.push_back(expected);
    endtask

    // all lanes share one exponent, so no lane is shifted.
    function automatic fp_word_t model_equal_exp(input fp_word_vec_t w);
        logic signed [31:0] total;
        logic signed [31:0] term;
        logic [31:0]        mag;
        logic [31:0]        norm;
        logic [7:0]         e;
        int                 pos;
        total = '0;
        for (int i = 0; i < LANES; i++) begin
            term = {8'd0, 1'b1, w[i][22:0]};
            total = w[i][31] ? total - term : total + term;
        end
        if (total == 0) begin
            return '0;
        end
        mag = (total < 0) ? -total : total;
        pos = 31;
        while (mag[pos] == 1'b0) begin
            pos--;
        end
        if (pos > 23) begin
            norm = mag >> (pos - 23);
        end else begin
            norm = mag << (23 - pos);
        end
        e = 8'(int'(w[0][30:23]) + pos - 23);
        return {total[31], e, norm[22:0]};
    endfunction

    task automatic add_random_rows();
        fp_word_vec_t v;
        logic [31:0]  r;
        logic [7:0]   e;
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            r = $random(seed);
            e = 8'd110 + {3'b000, r[4:0]};
            for (int i = 0; i < LANES; i++) begin
                r = $random(seed);
                v[i] = {r[31], e, r[22:0]};
            end
            names.push_back($sformatf("random_%0d", k));
            stim_q.push_back(v);
            expect_q.push_back(model_equal_exp(v));
        end
    endtask

    // ======================================================================
    // drive and collect
    // ======================================================================

    task automatic drive_all();
        for (int k = 0; k < stim_q.size(); k++) begin
            @(posedge clk);
            #1;
            in_valid = 1'b1;
            in_words = stim_q[k];
            sent_cycle_q.push_back(cycle);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic collect_all();
        int wait_cycles;
        int sent;
        int errs_before;
        for (int k = 0; k < stim_q.size(); k++) begin
            wait_cycles = 0;
            @(negedge clk);
            while (out_valid !== 1'b1 && wait_cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                wait_cycles++;
            end
            if (out_valid !== 1'b1) begin
                $display("timeout: out_valid never rose for test %s within %0d cycles",
                         names[k], TIMEOUT_CYCLES);
                timed_out = 1'b1;
                return;
            end
            errs_before = errors;
            sent = sent_cycle_q.pop_front();
            check_value({names[k], " word"}, expect_q[k], out_word);
            check_value({names[k], " latency"}, 32'(sent + PIPE_DEPTH), 32'(cycle));
            report_test(names[k], errs_before);
        end
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================

    initial begin
        int errs_before;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_words = '0;

        add_row("eight_ones", ONE, ONE, ONE, ONE, ONE, ONE, ONE, ONE, 32'h4100_0000);
        add_row("one_seven_halves", ONE, HALF, HALF, HALF, HALF, HALF, HALF, HALF,
                32'h4090_0000);
        add_row("eight_threes", THREE, THREE, THREE, THREE, THREE, THREE, THREE, THREE,
                32'h41C0_0000);
        add_row("tiny_dropped", ONE, TINY, TINY, TINY, TINY, TINY, TINY, TINY,
                32'h3F80_0000);
        // exact sum is a tie that rounding would carry to 2.0.
        add_row("truncated_sum", ONE, ALMOST_ONE, ONE, NEG_ONE, ONE, NEG_ONE, ONE, NEG_ONE,
                32'h3FFF_FFFF);
        add_row("negative_total", NEG_FOUR, ONE, HALF, NEG_HALF, HALF, NEG_HALF, HALF,
                NEG_HALF, 32'hC040_0000);
        add_row("pairs_cancel", ONE, NEG_ONE, 32'h4050_0000, 32'hC050_0000, HALF, NEG_HALF,
                THREE, 32'hC040_0000, 32'h0000_0000);
        // remainder of one lsb, normalized up by 23 places.
        add_row("small_remainder", ONE, NEG_ALMOST_ONE, ONE, NEG_ONE, ONE, NEG_ONE, ONE,
                NEG_ONE, 32'h3400_0000);
        add_random_rows();

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        errs_before = errors;
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            check_value("idle_after_reset", 32'd0, {31'd0, out_valid});
        end
        report_test("idle_after_reset", errs_before);

        fork
            drive_all();
            collect_all();
        join

        $display("%0d tests, %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
verilog/fp_sum_pkg.sv
verilog/fp_lanes_if.sv
verilog/lead_one_find.sv
verilog/fp_unpack.sv
verilog/fp_align_sum.sv
verilog/fp_normalize_pack.sv
verilog/fp_sum8.sv
bench/fp_sum8_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module fp_sum8_tb -o fp_sum8_sim \
    && ./obj_dir/fp_sum8_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && { echo "simulation FAILED"; exit 1; }
echo "simulation PASSED"
exit 0
